//--- pcAccel_defines.svh
// Sizing macros shared by the package, the RTL and the testbench
// PORT_WIDTH must hold the 2-bit opcode plus two buffer address fields
// BUF_DEPTH must equal 2**BUF_ADDR_WIDTH so that addresses wrap for free
`ifndef PCACCEL_DEFINES_SVH
`define PCACCEL_DEFINES_SVH

// ====================
// Pad and buffer
// ====================
// One pad beat carries exactly one buffer word
`define PORT_WIDTH 32

`define BUF_DEPTH 64
`define BUF_ADDR_WIDTH 6

// ====================
// Start button
// ====================
// Equal samples before the filtered level follows the pin
`define DEB_CYCLES 8

`endif

//--- pcAccelPkg.sv
// Types shared by the host interface, the control unit and the buffer
// Headers and payload words use the same pad bus, so one word has two views
`include "pcAccel_defines.svh"

package pcAccelPkg;

    // Command opcode
    // Code 3 has no name and decodes as a no-op
    typedef enum logic [1:0] {
        LOAD   = 2'd0,
        STORE  = 2'd1,
        FINISH = 2'd2
    } cmdOp_e;

    // Header view of one host word
    typedef struct packed {
        cmdOp_e                                     opcode;
        logic [`BUF_ADDR_WIDTH-1:0]                 lengthM1;
        logic [`BUF_ADDR_WIDTH-1:0]                 baseAddr;
        logic [`PORT_WIDTH-2-2*`BUF_ADDR_WIDTH-1:0] reserved;
    } cmdHdr_s;

    typedef union packed {
        cmdHdr_s                hdr;
        logic [`PORT_WIDTH-1:0] raw;
    } hostWord_u;

    typedef struct packed {
        logic [`PORT_WIDTH-1:0] dat;
        logic                   vld;
        logic                   last;
    } padBeat_s;

    typedef struct packed {
        logic [`BUF_ADDR_WIDTH-1:0] addr;
        logic [`PORT_WIDTH-1:0]     dat;
        logic                       vld;
    } bufWrite_s;

    typedef struct packed {
        logic [`BUF_ADDR_WIDTH-1:0] addr;
        logic                       vld;
    } bufRdReq_s;

endpackage

//--- startDebounce.sv
// Debounce filter for the start button
// The pin goes through a two-flop synchronizer before it is filtered
// A run starts on release, i.e. when the filtered level falls
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module startDebounce (
    input  logic clk,
    input  logic arstN,
    input  logic button,
    output logic startPulse
);

    localparam int CNT_WIDTH = $clog2(`DEB_CYCLES);

    logic [1:0]           btnSync;
    logic [CNT_WIDTH-1:0] sampleCnt;
    logic                 btnLevel;
    logic                 btnLevelDly;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btnSync     <= 2'b00;
            sampleCnt   <= '0;
            btnLevel    <= 1'b0;
            btnLevelDly <= 1'b0;
        end else begin
            btnSync     <= {btnSync[0], button};
            btnLevelDly <= btnLevel;
            // A sample equal to the level restarts the count
            if (btnSync[1] == btnLevel) begin
                sampleCnt <= '0;
            end else if (sampleCnt == CNT_WIDTH'(`DEB_CYCLES - 1)) begin
                sampleCnt <= '0;
                btnLevel  <= btnSync[1];
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // Falling edge of the filtered level
    assign startPulse = btnLevelDly & ~btnLevel;

endmodule

//--- hostInterface.sv
// Register stages between the pad bus and the control unit
// One holding register inbound, so the pad takes at most one beat per two cycles
// The incoming last flag is ignored, lengths come from the command header
// Outbound beats wait in the output register until the host is ready
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module hostInterface
    import pcAccelPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  padBeat_s  padIn,
    output logic      padInRdy,
    output padBeat_s  padOut,
    input  logic      padOutRdy,
    input  logic      padOutEn,
    input  logic      rxEn,
    output hostWord_u hostWord,
    output logic      hostWordVld,
    input  logic      hostWordRdy,
    input  padBeat_s  sendBeat,
    output logic      sendRdy
);

    logic                   inVld;
    hostWord_u              inHold;

    logic                   outVld;
    logic                   outLast;
    logic [`PORT_WIDTH-1:0] outDat;

    logic                   padInTake;
    logic                   padOutTake;
    logic                   sendTake;

    // ====================
    // Inbound path
    // ====================
    // Host drives the bus, register free, controller listening
    assign padInRdy  = ~padOutEn & ~inVld & rxEn;
    assign padInTake = padIn.vld & padInRdy;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inVld <= 1'b0;
        end else if (padInTake) begin
            inVld <= 1'b1;
        end else if (inVld & hostWordRdy) begin
            inVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (padInTake) begin
            inHold.raw <= padIn.dat;
        end
    end

    assign hostWord    = inHold;
    assign hostWordVld = inVld;

    // ====================
    // Outbound path
    // ====================
    assign padOutTake = outVld & padOutRdy & padOutEn;
    // Stalls while a beat still waits on the host
    assign sendRdy    = padOutEn & (~outVld | padOutRdy);
    assign sendTake   = sendBeat.vld & sendRdy;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outVld  <= 1'b0;
            outLast <= 1'b0;
        end else if (sendTake) begin
            outVld  <= 1'b1;
            outLast <= sendBeat.last;
        end else if (padOutTake) begin
            outVld  <= 1'b0;
            outLast <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sendTake) begin
            outDat <= sendBeat.dat;
        end
    end

    assign padOut = '{dat: outDat, vld: outVld, last: outLast};

endmodule

//--- globalBuffer.sv
// Word buffer with one write port and one read port
// Writes are taken on the clock edge and never stall
// Reads return one cycle after the address and hold under back-pressure
// A read and a write to the same address in one cycle return the old word
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module globalBuffer
    import pcAccelPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  bufWrite_s              wr,
    input  bufRdReq_s              rdReq,
    output logic                   rdReqRdy,
    output logic [`PORT_WIDTH-1:0] rdDat,
    output logic                   rdVld,
    input  logic                   rdRdy
);

    logic [`PORT_WIDTH-1:0] mem [`BUF_DEPTH];
    logic                   rdTake;

    // ====================
    // Write port
    // ====================
    always_ff @(posedge clk) begin
        if (wr.vld) begin
            mem[wr.addr] <= wr.dat;
        end
    end

    // ====================
    // Read port
    // ====================
    // Output stage empty or draining this cycle
    assign rdReqRdy = ~rdVld | rdRdy;
    assign rdTake   = rdReq.vld & rdReqRdy;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdVld <= 1'b0;
        end else if (rdReqRdy) begin
            rdVld <= rdReq.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rdTake) begin
            rdDat <= mem[rdReq.addr];
        end
    end

endmodule

//--- controlUnit.sv
// Command decoder and transfer sequencer for the host bus
// No command is taken before the first start pulse
// Buffer addresses wrap at BUF_DEPTH, a transfer covers lengthM1+1 words
// FINISH parks the unit until the next start pulse, which clears netFnh
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module controlUnit
    import pcAccelPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   startPulse,
    input  hostWord_u              hostWord,
    input  logic                   hostWordVld,
    output logic                   hostWordRdy,
    output logic                   rxEn,
    output bufWrite_s              wr,
    output bufRdReq_s              rdReq,
    input  logic                   rdReqRdy,
    input  logic [`PORT_WIDTH-1:0] rdDat,
    input  logic                   rdVld,
    output logic                   rdRdy,
    output padBeat_s               sendBeat,
    input  logic                   sendRdy,
    output logic                   padOutEn,
    output logic                   netFnh
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_LOAD,
        ST_STORE
    } ctlState_e;

    ctlState_e                  state;
    logic [`BUF_ADDR_WIDTH-1:0] addr;
    logic [`BUF_ADDR_WIDTH-1:0] wordCnt;
    logic [`BUF_ADDR_WIDTH-1:0] sendCnt;
    logic                       reqPending;
    logic                       lastSent;

    logic                       wrVld;
    logic [`BUF_ADDR_WIDTH-1:0] wrAddr;
    logic [`PORT_WIDTH-1:0]     wrDat;

    logic                       hostTake;
    logic                       rdTake;
    logic                       sendTake;

    assign rxEn        = (state == ST_HEADER) | (state == ST_LOAD);
    assign hostWordRdy = rxEn;
    assign hostTake    = hostWordVld & hostWordRdy;

    // Read side of a store, buffer data goes straight to the pad stage
    assign rdReq    = '{addr: addr, vld: reqPending};
    assign rdTake   = reqPending & rdReqRdy;
    assign rdRdy    = sendRdy;
    assign sendBeat = '{dat: rdDat, vld: rdVld, last: (sendCnt == '0)};
    assign sendTake = rdVld & sendRdy;

    assign wr = '{addr: wrAddr, dat: wrDat, vld: wrVld};

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= ST_IDLE;
            addr       <= '0;
            wordCnt    <= '0;
            sendCnt    <= '0;
            reqPending <= 1'b0;
            lastSent   <= 1'b0;
            wrVld      <= 1'b0;
            padOutEn   <= 1'b0;
            netFnh     <= 1'b0;
        end else begin
            wrVld <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (startPulse) begin
                        netFnh <= 1'b0;
                        state  <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (hostTake) begin
                        addr    <= hostWord.hdr.baseAddr;
                        wordCnt <= hostWord.hdr.lengthM1;
                        sendCnt <= hostWord.hdr.lengthM1;
                        case (hostWord.hdr.opcode)
                            LOAD: begin
                                state <= ST_LOAD;
                            end
                            STORE: begin
                                // Bus turns toward the host right away
                                reqPending <= 1'b1;
                                padOutEn   <= 1'b1;
                                state      <= ST_STORE;
                            end
                            FINISH: begin
                                netFnh <= 1'b1;
                                state  <= ST_IDLE;
                            end
                            default: begin
                                state <= ST_HEADER;
                            end
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (hostTake) begin
                        wrVld   <= 1'b1;
                        addr    <= addr + 1'b1;
                        wordCnt <= wordCnt - 1'b1;
                        if (wordCnt == '0) begin
                            state <= ST_HEADER;
                        end
                    end
                end
                ST_STORE: begin
                    if (rdTake) begin
                        addr    <= addr + 1'b1;
                        wordCnt <= wordCnt - 1'b1;
                        if (wordCnt == '0) begin
                            reqPending <= 1'b0;
                        end
                    end
                    if (sendTake) begin
                        sendCnt <= sendCnt - 1'b1;
                        if (sendCnt == '0) begin
                            lastSent <= 1'b1;
                        end
                    end
                    // Final beat leaves the pad stage on this edge
                    if (lastSent & sendRdy) begin
                        lastSent <= 1'b0;
                        padOutEn <= 1'b0;
                        state    <= ST_HEADER;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Load payload, written one cycle after it is taken
    always_ff @(posedge clk) begin
        if ((state == ST_LOAD) && hostTake) begin
            wrAddr <= addr;
            wrDat  <= hostWord.raw;
        end
    end

endmodule

//--- pcAccelTop.sv
// Top level of the host side of the point-cloud accelerator
// The pad bus turns around with datOE. While it is high the core drives
// data, vld and last and the host drives ready, otherwise the reverse
// A beat moves on a rising clk edge with vld and rdy both high
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module pcAccelTop
    import pcAccelPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   startButton,
    inout  wire  [`PORT_WIDTH-1:0] ioDat,
    inout  wire                    ioDatVld,
    inout  wire                    ioDatLast,
    inout  wire                    ioDatRdy,
    output logic                   datOE,
    output logic                   netFnh
);

    logic                   startPulse;
    padBeat_s               padIn;
    padBeat_s               padOut;
    logic                   padInRdy;
    hostWord_u              hostWord;
    logic                   hostWordVld;
    logic                   hostWordRdy;
    logic                   rxEn;
    padBeat_s               sendBeat;
    logic                   sendRdy;
    bufWrite_s              bufWr;
    bufRdReq_s              rdReq;
    logic                   rdReqRdy;
    logic [`PORT_WIDTH-1:0] rdDat;
    logic                   rdVld;
    logic                   rdRdy;

    // ====================
    // Pad tri-state
    // ====================
    assign ioDat     = datOE ? padOut.dat  : {`PORT_WIDTH{1'bz}};
    assign ioDatVld  = datOE ? padOut.vld  : 1'bz;
    assign ioDatLast = datOE ? padOut.last : 1'bz;
    assign ioDatRdy  = datOE ? 1'bz        : padInRdy;

    assign padIn = '{dat: ioDat, vld: ioDatVld, last: ioDatLast};

    // ====================
    // Instances
    // ====================
    startDebounce startDebounce_i (
        .clk(clk), .arstN(arstN),
        .button(startButton),
        .startPulse(startPulse)
    );

    // Pad ready pin feeds the outbound stage while datOE is high
    hostInterface hostInterface_i (
        .clk(clk), .arstN(arstN),
        .padIn(padIn), .padInRdy(padInRdy),
        .padOut(padOut), .padOutRdy(ioDatRdy), .padOutEn(datOE),
        .rxEn(rxEn),
        .hostWord(hostWord), .hostWordVld(hostWordVld), .hostWordRdy(hostWordRdy),
        .sendBeat(sendBeat), .sendRdy(sendRdy)
    );

    controlUnit controlUnit_i (
        .clk(clk), .arstN(arstN),
        .startPulse(startPulse),
        .hostWord(hostWord), .hostWordVld(hostWordVld), .hostWordRdy(hostWordRdy),
        .rxEn(rxEn),
        .wr(bufWr),
        .rdReq(rdReq), .rdReqRdy(rdReqRdy),
        .rdDat(rdDat), .rdVld(rdVld), .rdRdy(rdRdy),
        .sendBeat(sendBeat), .sendRdy(sendRdy),
        .padOutEn(datOE),
        .netFnh(netFnh)
    );

    globalBuffer globalBuffer_i (
        .clk(clk), .arstN(arstN),
        .wr(bufWr),
        .rdReq(rdReq), .rdReqRdy(rdReqRdy),
        .rdDat(rdDat), .rdVld(rdVld), .rdRdy(rdRdy)
    );

endmodule

//--- pcAccelTb.sv
// Testbench for the host side of the point-cloud accelerator
// The host pins are driven while datOE is low and sampled on the falling clock edge
// Buffer words outside the loaded regions are never read back
// Stimulus and payload come from a command table and a seeded $random
`timescale 1ns/100ps
`include "pcAccel_defines.svh"

module pcAccelTb
    import pcAccelPkg::*;
();

    localparam int N_TESTS = 9;

    typedef struct packed {
        cmdOp_e                     op;
        logic [`BUF_ADDR_WIDTH-1:0] lenM1;
        logic [`BUF_ADDR_WIDTH-1:0] base;
        logic                       rndRdy;
        logic                       newStart;
    } testEntry_s;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic                   startButton;
    logic [`PORT_WIDTH-1:0] tbDat;
    logic                   tbVld;
    logic                   tbLast;
    logic                   tbRdy;
    wire  [`PORT_WIDTH-1:0] ioDat;
    wire                    ioDatVld;
    wire                    ioDatLast;
    wire                    ioDatRdy;
    wire                    datOE;
    wire                    netFnh;

    testEntry_s             cmdTable [N_TESTS];
    logic [`PORT_WIDTH-1:0] payload [N_TESTS][`BUF_DEPTH];
    logic [`PORT_WIDTH-1:0] refMem [`BUF_DEPTH];
    integer                 seed = 32'hf1c872ef;
    int                     errCnt = 0;
    int                     checkCnt = 0;
    int                     testCnt = 0;
    int                     cycleLimit = 0;
    int                     cycleCnt = 0;
    int                     errBefore;

    always #50 clk = ~clk;

    // Host side of the pad bus
    assign ioDat     = datOE ? {`PORT_WIDTH{1'bz}} : tbDat;
    assign ioDatVld  = datOE ? 1'bz : tbVld;
    assign ioDatLast = datOE ? 1'bz : tbLast;
    assign ioDatRdy  = datOE ? tbRdy : 1'bz;

    pcAccelTop pcAccelTop_i (
        .clk(clk), .arstN(arstN), .startButton(startButton),
        .ioDat(ioDat), .ioDatVld(ioDatVld), .ioDatLast(ioDatLast), .ioDatRdy(ioDatRdy),
        .datOE(datOE), .netFnh(netFnh)
    );

    // ====================
    // Helpers
    // ====================
    task automatic checkVal(input string name, input logic [`PORT_WIDTH-1:0] act,
                            input logic [`PORT_WIDTH-1:0] exp);
        checkCnt++;
        if (act !== exp) begin
            errCnt++;
            $display("Fail %s: got %h, expected %h", name, act, exp);
        end
    endtask

    task automatic reportTest(input string name, input int errStart);
        testCnt++;
        if (errCnt == errStart) begin
            $display("Test %0d %s: ok", testCnt, name);
        end else begin
            $display("Test %0d %s: %0d errors", testCnt, name, errCnt - errStart);
        end
    endtask

    function automatic logic [`PORT_WIDTH-1:0] makeHeader(cmdOp_e op, int lenM1, int base);
        hostWord_u hw;
        hw.raw             = '0;
        hw.hdr.opcode      = op;
        hw.hdr.lengthM1    = lenM1[`BUF_ADDR_WIDTH-1:0];
        hw.hdr.baseAddr    = base[`BUF_ADDR_WIDTH-1:0];
        return hw.raw;
    endfunction

    // One inbound beat, held until the DUT takes it
    task automatic sendWord(input logic [`PORT_WIDTH-1:0] w);
        @(posedge clk);
        tbDat <= w;
        tbVld <= 1'b1;
        @(negedge clk);
        while (!ioDatRdy) @(negedge clk);
        @(posedge clk);
        tbVld <= 1'b0;
    endtask

    // Clean press and release, then wait for the ready pin
    task automatic pressButton();
        int waited;
        waited = 0;
        @(posedge clk);
        startButton <= 1'b1;
        repeat (`DEB_CYCLES + 4) @(posedge clk);
        startButton <= 1'b0;
        @(negedge clk);
        while (!ioDatRdy && waited < 4 * `DEB_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        checkVal("ioDatRdy", 32'(ioDatRdy), 32'd1);
    endtask

    task automatic receiveStore(input int base, input int lenM1, input logic rndRdy);
        int                         got;
        logic [`BUF_ADDR_WIDTH-1:0] a;
        logic                       held;
        logic [`PORT_WIDTH-1:0]     heldDat;
        logic [31:0]                rnd;
        got  = 0;
        held = 1'b0;
        a    = base[`BUF_ADDR_WIDTH-1:0];
        @(negedge clk);
        while (!datOE) @(negedge clk);
        while (got <= lenM1) begin
            rnd = $random(seed);
            @(posedge clk);
            tbRdy <= rndRdy ? rnd[0] : 1'b1;
            @(negedge clk);
            // A stalled beat must stay on the pins
            if (held) begin
                checkVal("ioDat", ioDat, heldDat);
                checkVal("ioDatVld", 32'(ioDatVld), 32'd1);
            end
            held = 1'b0;
            if (ioDatVld && ioDatRdy) begin
                checkVal("ioDat", ioDat, refMem[a]);
                checkVal("ioDatLast", 32'(ioDatLast), (got == lenM1) ? 32'd1 : 32'd0);
                a = a + 1'b1;
                got++;
            end else if (ioDatVld) begin
                held    = 1'b1;
                heldDat = ioDat;
            end
        end
        @(posedge clk);
        tbRdy <= 1'b0;
        @(negedge clk);
        checkVal("datOE", 32'(datOE), 32'd0);
    endtask

    task automatic runEntry(input int e);
        testEntry_s                 t;
        cmdOp_e                     op;
        logic [`BUF_ADDR_WIDTH-1:0] a;
        int                         errStart;
        t        = cmdTable[e];
        op       = t.op;
        a        = t.base;
        errStart = errCnt;
        if (t.newStart) begin
            pressButton();
            checkVal("netFnh", 32'(netFnh), 32'd0);
        end
        sendWord(makeHeader(op, int'(t.lenM1), int'(t.base)));
        case (op)
            LOAD: begin
                for (int i = 0; i <= int'(t.lenM1); i++) begin
                    sendWord(payload[e][i]);
                    refMem[a] = payload[e][i];
                    a = a + 1'b1;
                end
            end
            STORE: begin
                receiveStore(int'(t.base), int'(t.lenM1), t.rndRdy);
            end
            default: begin
                @(negedge clk);
                while (!netFnh) @(negedge clk);
                repeat (4) begin
                    @(negedge clk);
                    checkVal("netFnh", 32'(netFnh), 32'd1);
                    checkVal("ioDatRdy", 32'(ioDatRdy), 32'd0);
                end
            end
        endcase
        reportTest($sformatf("%s len %0d base %0d", op.name(), t.lenM1, t.base), errStart);
    endtask

    task automatic fillTable();
        cmdTable[0] = '{LOAD,   6'd7,  6'd4,  1'b0, 1'b0};
        cmdTable[1] = '{STORE,  6'd7,  6'd4,  1'b0, 1'b0};
        cmdTable[2] = '{LOAD,   6'd15, 6'd20, 1'b0, 1'b0};
        cmdTable[3] = '{STORE,  6'd15, 6'd20, 1'b1, 1'b0};
        // Wraps past the top of the buffer
        cmdTable[4] = '{LOAD,   6'd3,  6'd62, 1'b0, 1'b0};
        cmdTable[5] = '{STORE,  6'd3,  6'd62, 1'b1, 1'b0};
        cmdTable[6] = '{STORE,  6'd1,  6'd0,  1'b0, 1'b0};
        cmdTable[7] = '{FINISH, 6'd0,  6'd0,  1'b0, 1'b0};
        cmdTable[8] = '{FINISH, 6'd0,  6'd0,  1'b0, 1'b1};
        for (int e = 0; e < N_TESTS; e++) begin
            for (int w = 0; w < `BUF_DEPTH; w++) begin
                payload[e][w] = $random(seed);
            end
        end
    endtask

    // ====================
    // Watchdog
    // ====================
    initial begin
        wait (arstN === 1'b1);
        while (cycleCnt < cycleLimit) begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("Timeout: the DUT stopped responding after %0d cycles", cycleLimit);
        $display("=== FAIL ===");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        arstN       = 1'b0;
        startButton = 1'b0;
        tbDat       = '0;
        tbVld       = 1'b0;
        tbLast      = 1'b0;
        tbRdy       = 1'b0;
        fillTable();
        // Presses and bounces plus a generous budget per word
        cycleLimit = 400 + 40 * `DEB_CYCLES;
        for (int e = 0; e < N_TESTS; e++) begin
            cycleLimit += 12 * (int'(cmdTable[e].lenM1) + 2);
        end
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        // Header offered before any start
        errBefore = errCnt;
        @(posedge clk);
        tbDat <= makeHeader(LOAD, 0, 0);
        tbVld <= 1'b1;
        repeat (2 * `DEB_CYCLES) begin
            @(negedge clk);
            checkVal("ioDatRdy", 32'(ioDatRdy), 32'd0);
            checkVal("datOE", 32'(datOE), 32'd0);
            checkVal("netFnh", 32'(netFnh), 32'd0);
        end
        @(posedge clk);
        tbVld <= 1'b0;
        reportTest("reset and no start", errBefore);

        // Short bounces, then a clean press
        errBefore = errCnt;
        repeat (4) begin
            @(posedge clk);
            startButton <= 1'b1;
            repeat (3) @(posedge clk);
            startButton <= 1'b0;
            repeat (3) @(posedge clk);
        end
        repeat (3 * `DEB_CYCLES) begin
            @(negedge clk);
            checkVal("ioDatRdy", 32'(ioDatRdy), 32'd0);
        end
        pressButton();
        reportTest("debounce and start", errBefore);

        for (int e = 0; e < N_TESTS; e++) begin
            runEntry(e);
        end

        $display("Tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
pcAccelPkg.sv
startDebounce.sv
hostInterface.sv
globalBuffer.sv
controlUnit.sv
pcAccelTop.sv
pcAccelTb.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run, and fail when the log holds the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pcAccelTb -f flist.f -o simPcAccel \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simPcAccel > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
